// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_fetch_frontend
FILELIST  ?= fetch_frontend.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall

SOURCES := $(shell cat $(FILELIST))

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Simulation failed" $(LOG); then \
		echo "Run failed, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: fetch_frontend.f
fetch_geometry_pkg.sv
ibuffer_pkg.sv
fetch_ifs.sv
line_fetcher.sv
ibuffer.sv
inst_fifo.sv
fetch_frontend.sv
tb_clock_gen.sv
fetch_frontend_assertions.sv
tb_fetch_frontend.sv

// File: fetch_frontend.sv
`timescale 1ns/100ps
`default_nettype none

module fetch_frontend import fetch_geometry_pkg::*; (
    input  wire              clock,
    input  wire              reset_n,
    input  wire              redirect,      // Flush and restart
    input  wire [PC_W-1:0]   redirect_pc,   // Line aligned target
    output wire              mem_req,
    output wire [PC_W-1:0]   mem_addr,
    input  wire              mem_valid,
    input  wire [LINE_W-1:0] mem_line,
    output wire              inst_valid,    // Head entry present
    output wire [INST_W-1:0] inst,
    output wire [PC_W-1:0]   inst_pc,
    input  wire              inst_read      // Pop the head
);

    line_if      line_bus ();
    inst_fifo_if fifo_bus ();

    line_fetcher line_fetcher_i (
        .clock       (clock),
        .reset_n     (reset_n),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .mem_req     (mem_req),
        .mem_addr    (mem_addr),
        .mem_valid   (mem_valid),
        .mem_line    (mem_line),
        .line        (line_bus.fetcher)
    );

    ibuffer ibuffer_i (
        .clock     (clock),
        .reset_n   (reset_n),
        .redirect  (redirect),
        .line      (line_bus.buffer),
        .fifo      (fifo_bus.writer),
        .inst_read (inst_read)
    );

    inst_fifo inst_fifo_i (
        .clock   (clock),
        .reset_n (reset_n),
        .fifo    (fifo_bus.fifo)
    );

    assign inst_valid = !fifo_bus.empty;
    assign inst       = fifo_bus.data_out[ENTRY_W-1 -: INST_W];   // Upper part of the entry
    assign inst_pc    = fifo_bus.data_out[PC_W-1:0];

endmodule

`default_nettype wire

// File: fetch_frontend_assertions.sv
`timescale 1ns/100ps
`default_nettype none

module fetch_frontend_assertions import ibuffer_pkg::*; (
    input wire               clock,
    input wire               reset_n,
    input wire               mem_req,
    input wire               mem_valid,
    input wire               fetch_idle,    // No line request pending
    input wire [COUNT_W-1:0] count,         // FIFO occupancy
    input wire               read_en,
    input wire               clear,
    input wire               full
);

    // Occupancy bound
    count_in_range: assert property (@(posedge clock) disable iff (!reset_n)
        count <= COUNT_W'(FIFO_DEPTH))
        else $error("FIFO count %0d is above the FIFO depth", count);

    // A request only leaves when memory was free or just answered
    single_request: assert property (@(posedge clock) disable iff (!reset_n)
        mem_req |-> $past(fetch_idle || mem_valid))
        else $error("mem_req issued while a line request was still pending");

    // A full FIFO takes no write and only a pop lowers the count
    no_write_when_full: assert property (@(posedge clock) disable iff (!reset_n)
        full && !clear |=> count == ($past(read_en) ? COUNT_W'(FIFO_DEPTH - 1)
                                                    : COUNT_W'(FIFO_DEPTH)))
        else $error("FIFO accepted a write while full, count is now %0d", count);

endmodule

bind fetch_frontend fetch_frontend_assertions assertions_i (
    .clock      (clock),
    .reset_n    (reset_n),
    .mem_req    (mem_req),
    .mem_valid  (mem_valid),
    .fetch_idle (line_bus.fetch_idle),
    .count      (fifo_bus.count),
    .read_en    (fifo_bus.read_en),
    .clear      (fifo_bus.clear),
    .full       (fifo_bus.full)
);

`default_nettype wire

// File: fetch_geometry_pkg.sv
`default_nettype none

package fetch_geometry_pkg;

    localparam int INST_W     = 32;                   // One instruction word
    localparam int PC_W       = 48;                   // Implemented PC bits
    localparam int LINE_INSTS = 16;                   // Instruction slots per line
    localparam int LINE_W     = LINE_INSTS * INST_W;  // 512-bit memory line

    localparam int INST_BYTES = 4;                    // PC step inside a line
    localparam int LINE_BYTES = LINE_INSTS * INST_BYTES;  // PC step between lines

    // FIFO entry holds {instruction, pc}, instruction in the upper bits
    localparam int ENTRY_W    = INST_W + PC_W;

endpackage

`default_nettype wire

// File: fetch_ifs.sv
`timescale 1ns/100ps
`default_nettype none

// Line hand-off between the fetcher and the ibuffer
interface line_if import fetch_geometry_pkg::*; ();
    logic              line_ready;   // Level, high while a fresh line is shown
    logic [LINE_W-1:0] line_data;    // Sixteen instructions, slot 0 in the low bits
    logic [PC_W-1:0]   line_pc;      // PC of slot 0
    logic              fetch_idle;   // No memory request outstanding
    logic              fetch_inst;   // One-cycle refill request

    modport fetcher (output line_ready, line_data, line_pc, fetch_idle, input fetch_inst);
    modport buffer  (input line_ready, line_data, line_pc, fetch_idle, output fetch_inst);
endinterface

// Write/read side of the instruction FIFO
interface inst_fifo_if import fetch_geometry_pkg::*, ibuffer_pkg::*; ();
    logic [ENTRY_W-1:0] data_in;
    logic               write_en;    // Ignored while full
    logic               read_en;     // Ignored while empty
    logic               clear;       // Wins over read and write
    logic [ENTRY_W-1:0] data_out;    // Head entry, show-ahead
    logic               empty;
    logic               full;
    logic [COUNT_W-1:0] count;

    modport writer (output data_in, write_en, read_en, clear, input full, count);
    modport fifo   (input data_in, write_en, read_en, clear,
                    output data_out, empty, full, count);
endinterface

`default_nettype wire

// File: ibuffer.sv
`timescale 1ns/100ps
`default_nettype none

module ibuffer import fetch_geometry_pkg::*, ibuffer_pkg::*; (
    input  wire          clock,
    input  wire          reset_n,
    input  wire          redirect,     // Drops buffered and queued entries
    line_if.buffer       line,
    inst_fifo_if.writer  fifo,
    input  wire          inst_read     // Consumer pop
);

    logic [ENTRY_W-1:0]            entry_buf [LINE_INSTS];   // {inst, pc} per slot
    logic [$clog2(LINE_INSTS)-1:0] write_index;              // Next slot to push
    logic                          writing;                  // Line being streamed out
    logic                          line_ready_q;             // For edge detect
    logic                          line_rise;
    logic [COUNT_W-1:0]            fifo_count_q;             // Count one cycle back

    assign line_rise = line.line_ready && !line_ready_q;

    assign fifo.data_in  = entry_buf[write_index];
    assign fifo.write_en = writing && !fifo.full;             // Hold off while full
    assign fifo.read_en  = inst_read;
    assign fifo.clear    = redirect;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            line_ready_q <= 1'b0;
        end else begin
            line_ready_q <= line.line_ready;
        end
    end

    // Split the line, slot n gets line_pc + 4n
    always_ff @(posedge clock) begin
        if (line_rise) begin
            for (int i = 0; i < LINE_INSTS; i++) begin
                entry_buf[i] <= {line.line_data[i*INST_W +: INST_W],
                                 line.line_pc + PC_W'(i * INST_BYTES)};
            end
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            writing         <= 1'b0;
            write_index     <= '0;
            fifo_count_q    <= '0;
            line.fetch_inst <= 1'b0;
        end else if (redirect) begin
            writing         <= 1'b0;                  // Abandon the current line
            write_index     <= '0;
            fifo_count_q    <= '0;
            line.fetch_inst <= 1'b0;
        end else begin
            if (line_rise) begin
                write_index <= '0;
                writing     <= 1'b1;
            end else if (writing && !fifo.full) begin
                write_index <= write_index + 1'b1;
                if (write_index == $bits(write_index)'(LINE_INSTS - 1)) begin
                    writing <= 1'b0;                  // Last slot pushed
                end
            end

            fifo_count_q <= fifo.count;

            // Drained past the refill level with memory free
            line.fetch_inst <= (fifo_count_q == COUNT_W'(REFILL_LEVEL)) &&
                               (fifo.count == COUNT_W'(REFILL_LEVEL - 1)) &&
                               line.fetch_idle;
        end
    end

endmodule

`default_nettype wire

// File: ibuffer_pkg.sv
`default_nettype none

package ibuffer_pkg;

    localparam int FIFO_DEPTH   = 24;   // Instruction FIFO entries
    localparam int COUNT_W      = 5;    // Holds 0..FIFO_DEPTH

    // Refill is asked for when the count drops from this level to one below
    // it, which leaves a few instructions to cover the memory latency
    localparam int REFILL_LEVEL = 4;

endpackage

`default_nettype wire

// File: inst_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module inst_fifo import fetch_geometry_pkg::*, ibuffer_pkg::*; (
    input  wire       clock,
    input  wire       reset_n,
    inst_fifo_if.fifo fifo
);

    logic [ENTRY_W-1:0] mem [FIFO_DEPTH];   // Entry storage
    logic [COUNT_W-1:0] rd_ptr;             // Head slot
    logic [COUNT_W-1:0] wr_ptr;             // Next free slot
    logic [COUNT_W-1:0] count;
    logic               do_write;
    logic               do_read;

    assign fifo.empty    = (count == '0);
    assign fifo.full     = (count == COUNT_W'(FIFO_DEPTH));
    assign fifo.count    = count;
    assign fifo.data_out = mem[rd_ptr];            // Show-ahead head

    assign do_write = fifo.write_en && !fifo.full;
    assign do_read  = fifo.read_en && !fifo.empty;

    always_ff @(posedge clock) begin
        if (do_write && !fifo.clear) begin
            mem[wr_ptr] <= fifo.data_in;
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else if (fifo.clear) begin
            rd_ptr <= '0;                          // Flush in one cycle
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= (wr_ptr == COUNT_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= (rd_ptr == COUNT_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_write, do_read})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;           // Both or neither
            endcase
        end
    end

endmodule

`default_nettype wire

// File: line_fetcher.sv
`timescale 1ns/100ps
`default_nettype none

module line_fetcher import fetch_geometry_pkg::*; (
    input  wire              clock,
    input  wire              reset_n,
    input  wire              redirect,      // Restart at redirect_pc
    input  wire [PC_W-1:0]   redirect_pc,   // Always line aligned
    output logic             mem_req,       // One-cycle request strobe
    output logic [PC_W-1:0]  mem_addr,      // Held after the strobe, marks the line in flight
    input  wire              mem_valid,     // One-cycle answer strobe
    input  wire [LINE_W-1:0] mem_line,
    line_if.fetcher          line
);

    logic [PC_W-1:0] next_pc;       // Line to fetch on the next refill
    logic            outstanding;   // Request issued, answer not yet seen
    logic            stale;         // Outstanding request was superseded by a redirect
    logic            good_line;     // Answer belongs to the current stream

    assign good_line = outstanding && mem_valid && !stale && !redirect;

    assign line.fetch_idle = !outstanding;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            mem_req         <= 1'b0;
            mem_addr        <= '0;
            next_pc         <= '0;
            outstanding     <= 1'b0;
            stale           <= 1'b0;
            line.line_ready <= 1'b0;
        end else begin
            mem_req <= 1'b0;                                // Strobe lasts one cycle
            if (redirect) begin
                if (outstanding && !mem_valid) begin
                    next_pc <= redirect_pc;                 // Wait for the old answer first
                    stale   <= 1'b1;
                end else begin
                    mem_req         <= 1'b1;                // Memory is free, go now
                    mem_addr        <= redirect_pc;
                    next_pc         <= redirect_pc + PC_W'(LINE_BYTES);
                    outstanding     <= 1'b1;
                    stale           <= 1'b0;
                    line.line_ready <= 1'b0;
                end
            end else if (outstanding && mem_valid) begin
                if (stale) begin
                    mem_req  <= 1'b1;                       // Drop the line, ask for the new one
                    mem_addr <= next_pc;
                    next_pc  <= next_pc + PC_W'(LINE_BYTES);
                    stale    <= 1'b0;
                end else begin
                    outstanding     <= 1'b0;
                    line.line_ready <= 1'b1;                // Announce the line
                end
            end else if (line.fetch_inst && !outstanding) begin
                mem_req         <= 1'b1;                    // Sequential refill
                mem_addr        <= next_pc;
                next_pc         <= next_pc + PC_W'(LINE_BYTES);
                outstanding     <= 1'b1;
                line.line_ready <= 1'b0;
            end
        end
    end

    // Line payload, held until the next good answer
    always_ff @(posedge clock) begin
        if (good_line) begin
            line.line_data <= mem_line;
            line.line_pc   <= mem_addr;                     // Address of the request just answered
        end
    end

endmodule

`default_nettype wire

// File: tb_clock_gen.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen (
    output logic clock,
    output logic reset_n
);

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;      // 8 ns period
    end

    initial begin
        reset_n = 1'b0;
        repeat (4) @(posedge clock);    // Held for four cycles
        @(negedge clock);
        reset_n = 1'b1;                 // Released on a falling edge like all inputs
    end

endmodule

`default_nettype wire

// File: tb_fetch_frontend.sv
`timescale 1ns/100ps
`default_nettype none

module tb_fetch_frontend import fetch_geometry_pkg::*; ();

    typedef struct packed {
        logic [PC_W-1:0] pc;           // Redirect target, line aligned
        logic [15:0]     length;       // Instructions to consume
        logic [7:0]      stall_pct;    // Chance the consumer skips a cycle
        logic            in_flight;    // Redirect while a line request is pending
    } row_t;

    row_t rows [6] = '{
        '{48'h0000_0000_1000, 16'd12, 8'd0,  1'b0},    // One line, eager consumer
        '{48'h0000_0001_0040, 16'd40, 8'd70, 1'b0},    // Three lines, refills
        '{48'h0000_8000_0fc0, 16'd60, 8'd90, 1'b0},    // Slow consumer keeps FIFO deep
        '{48'h0000_00ab_cd00, 16'd20, 8'd80, 1'b1},
        '{48'h1234_5678_9ac0, 16'd30, 8'd75, 1'b1},
        '{48'hffff_ffff_ff80, 16'd24, 8'd70, 1'b0}     // Top of the PC range
    };

    logic              clock;
    logic              reset_n;
    logic              redirect;
    logic [PC_W-1:0]   redirect_pc;
    logic              mem_valid = 1'b0;
    logic [LINE_W-1:0] mem_line = '0;
    logic              inst_read;
    wire               mem_req;
    wire  [PC_W-1:0]   mem_addr;
    wire               inst_valid;
    wire  [INST_W-1:0] inst;
    wire  [PC_W-1:0]   inst_pc;

    logic              pending = 1'b0;    // Memory owes an answer
    logic [PC_W-1:0]   pending_addr;
    int                wait_cycles;
    integer            seed = 32'h4ae6_c19c;
    int                error_count = 0;
    int                tests_passed = 0;
    int                tests_failed = 0;
    int                cycle_count = 0;
    int                cycle_limit = 0;

    tb_clock_gen clock_gen_i (.clock (clock), .reset_n (reset_n));

    fetch_frontend dut_i (
        .clock       (clock),
        .reset_n     (reset_n),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .mem_req     (mem_req),
        .mem_addr    (mem_addr),
        .mem_valid   (mem_valid),
        .mem_line    (mem_line),
        .inst_valid  (inst_valid),
        .inst        (inst),
        .inst_pc     (inst_pc),
        .inst_read   (inst_read)
    );

    function automatic logic [INST_W-1:0] inst_at(input logic [PC_W-1:0] addr);
        return addr[INST_W-1:0] ^ 32'h5a5a_0000;    // Memory content rule
    endfunction

    function automatic logic [LINE_W-1:0] line_at(input logic [PC_W-1:0] addr);
        logic [LINE_W-1:0] data;
        for (int i = 0; i < LINE_INSTS; i++) begin
            data[i*INST_W +: INST_W] = inst_at(addr + PC_W'(i * INST_BYTES));  // Slot 0 lowest
        end
        return data;
    endfunction

    // Memory model, answers each request after 1 to 4 cycles
    always @(negedge clock) begin
        mem_valid = 1'b0;
        if (pending) begin
            if (wait_cycles == 1) begin
                mem_valid = 1'b1;
                mem_line  = line_at(pending_addr);
                pending   = 1'b0;
            end else begin
                wait_cycles = wait_cycles - 1;
            end
        end
        if (mem_req) begin
            assert (!pending) else begin
                $display("%0t: memory got a request while the previous one was unanswered",
                         $time);
                error_count++;
            end
            // Requests always name a whole line
            assert ((mem_addr & PC_W'(LINE_BYTES - 1)) == '0) else begin
                $display("mismatch at %0t: mem_addr %h is not line aligned", $time, mem_addr);
                error_count++;
            end
            pending      = 1'b1;
            pending_addr = mem_addr;
            wait_cycles  = 1 + int'($unsigned($random(seed)) % 4);
        end
    end

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("Timeout: the tests did not finish within %0d clock cycles", cycle_limit);
            $display("Simulation failed");
            $finish;
        end
    end

    task automatic report_test(input string name, input int errors);
        if (errors == 0) begin
            tests_passed++;
            $display("%s: ok", name);
        end else begin
            tests_failed++;
            $display("%s: %0d errors", name, errors);
        end
    endtask

    task automatic check_idle(input int cycles);
        repeat (cycles) begin
            @(negedge clock);
            assert (!inst_valid && !mem_req) else begin
                $display("mismatch at %0t: inst_valid %b mem_req %b before any redirect, %s",
                         $time, inst_valid, mem_req, "expected 0 0");
                error_count++;
            end
        end
    endtask

    task automatic issue_redirect(input logic [PC_W-1:0] pc, input logic in_flight);
        @(negedge clock);
        inst_read   = 1'b0;
        redirect    = 1'b1;
        redirect_pc = in_flight ? pc + 48'h0000_0100_0000 : pc;   // Decoy line goes first
        if (in_flight) begin
            @(negedge clock);
            redirect_pc = pc;                  // Decoy request is pending now
        end
        @(negedge clock);
        redirect = 1'b0;
        assert (!inst_valid) else begin
            $display("mismatch at %0t: inst_valid still high after the redirect flush", $time);
            error_count++;
        end
    endtask

    task automatic consume(input logic [PC_W-1:0] start_pc, input int length,
                           input int stall_pct);
        logic [PC_W-1:0] exp_pc;
        int              taken;
        exp_pc = start_pc;
        taken  = 0;
        while (taken < length) begin
            @(negedge clock);
            if (inst_valid && int'($unsigned($random(seed)) % 100) >= stall_pct) begin
                inst_read = 1'b1;              // Head pops at the next rising edge
                assert (inst_pc == exp_pc && inst == inst_at(exp_pc)) else begin
                    $display("mismatch at %0t: read %0d got pc %h inst %h, expected pc %h inst %h",
                             $time, taken, inst_pc, inst, exp_pc, inst_at(exp_pc));
                    error_count++;
                end
                exp_pc = exp_pc + PC_W'(INST_BYTES);
                taken++;
            end else begin
                inst_read = 1'b0;
            end
        end
        @(negedge clock);
        inst_read = 1'b0;
    endtask

    initial begin
        int total;
        int errors_before;
        redirect    = 1'b0;
        redirect_pc = '0;
        inst_read   = 1'b0;
        total       = 0;
        foreach (rows[r]) begin
            total += int'(rows[r].length);
        end
        cycle_limit = 60 * total + 200;        // Slack for reset and memory latency
        wait (reset_n === 1'b1);
        errors_before = error_count;
        check_idle(10);
        report_test("idle after reset", error_count - errors_before);
        foreach (rows[r]) begin
            errors_before = error_count;
            issue_redirect(rows[r].pc, rows[r].in_flight);
            consume(rows[r].pc, int'(rows[r].length), int'(rows[r].stall_pct));
            report_test($sformatf("row %0d, pc %h, %0d instructions", r, rows[r].pc,
                                  rows[r].length), error_count - errors_before);
        end
        $display("%0d tests passed, %0d tests failed, %0d errors", tests_passed, tests_failed,
                 error_count);
        if (tests_failed == 0 && error_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
